/* filelist.f */
+incdir+tb
rtl/rv_isa_pkg.sv
rtl/cpu_cfg_pkg.sv
rtl/hazard_if.sv
rtl/reg_file.sv
rtl/alu.sv
rtl/fetch_decode.sv
rtl/execute_mem.sv
rtl/hazard_unit.sv
rtl/cpu_top.sv
tb/cpu_checker.sv
tb/cpu_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS    := $(shell grep -v '^+' $(FILELIST)) $(wildcard tb/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TEST PASS" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb/rv_ref_model.svh */
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

localparam int PROG_LEN   = 201;
localparam int HALT_IDX   = PROG_LEN - 1;
localparam int IMEM_WORDS = 256;
localparam int DMEM_WORDS = 64;

cpu_cfg_pkg::word_t imem [IMEM_WORDS];
logic [31:0]        rng_state;
dm_addr_t           st_addr_q [$];
cpu_cfg_pkg::word_t st_data_q [$];
int                 model_loads;

function automatic logic [31:0] lcg_next();
  rng_state = rng_state * 32'd1664525 + 32'd1013904223;
  return rng_state;
endfunction

// Upper LCG bits have the longer period
function automatic int unsigned pick(int unsigned n);
  return (lcg_next() >> 12) % n;
endfunction

function automatic cpu_cfg_pkg::word_t dmem_fill(int idx);
  return 32'(idx) * 32'h9e37_79b1 + 32'h0bad_0000;
endfunction

// ---------------------------------------------------------------------------
// RV32I encoders
// ---------------------------------------------------------------------------
function automatic cpu_cfg_pkg::word_t r_type(logic [6:0] f7, logic [4:0] rs2,
                                              logic [4:0] rs1, logic [2:0] f3,
                                              logic [4:0] rd);
  return {f7, rs2, rs1, f3, rd, rv_isa_pkg::OP_REG};
endfunction

function automatic cpu_cfg_pkg::word_t i_type(logic [11:0] imm, logic [4:0] rs1,
                                              logic [2:0] f3, logic [4:0] rd,
                                              logic [6:0] op);
  return {imm, rs1, f3, rd, op};
endfunction

function automatic cpu_cfg_pkg::word_t s_type(logic [11:0] imm, logic [4:0] rs2,
                                              logic [4:0] rs1);
  return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rv_isa_pkg::OP_STORE};
endfunction

function automatic cpu_cfg_pkg::word_t b_type(logic [12:0] off, logic [4:0] rs2,
                                              logic [4:0] rs1, logic [2:0] f3);
  return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_isa_pkg::OP_BRANCH};
endfunction

function automatic cpu_cfg_pkg::word_t j_type(logic [20:0] off, logic [4:0] rd);
  return {off[20], off[10:1], off[11], off[19:12], rd, rv_isa_pkg::OP_JAL};
endfunction

// ---------------------------------------------------------------------------
// Program generator
// ---------------------------------------------------------------------------
task automatic gen_program();
  int unsigned kind;
  int unsigned span;
  int unsigned bf;
  logic [4:0]  rd;
  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic [2:0]  f3;
  logic [11:0] imm;
  logic        alt;
  rng_state = 32'h79dd;
  // Unused words hold NOPs whose immediate is the word index
  for (int i = 0; i < IMEM_WORDS; i++) begin
    imem[i] = i_type(12'(i), 5'd0, 3'b000, 5'd0, rv_isa_pkg::OP_IMM);
  end
  for (int i = 0; i < HALT_IDX; i++) begin
    rd   = 5'(pick(8));
    rs1  = 5'(pick(8));
    rs2  = 5'(pick(8));
    f3   = 3'(pick(8));
    kind = pick(16);
    span = 1 + pick(4);
    if (i + span > HALT_IDX) begin
      span = HALT_IDX - i;
    end
    if (kind < 5) begin
      // Bit 30 only matters for SUB and SRA
      alt     = (f3 == 3'b000 || f3 == 3'b101) && (pick(2) == 1);
      imem[i] = r_type(alt ? 7'b0100000 : 7'b0, rs2, rs1, f3, rd);
    end else if (kind < 9) begin
      if (f3 == 3'b001) begin
        imm = {7'b0, rs2};
      end else if (f3 == 3'b101) begin
        imm = {(pick(2) == 1) ? 7'b0100000 : 7'b0, 5'(pick(32))};
      end else begin
        imm = 12'(pick(4096));
      end
      imem[i] = i_type(imm, rs1, f3, rd, rv_isa_pkg::OP_IMM);
    end else if (kind < 10) begin
      imem[i] = {20'(lcg_next()), rd, rv_isa_pkg::OP_LUI};
    end else if (kind < 12) begin
      imm     = {4'b0, 6'(pick(DMEM_WORDS)), 2'b00};
      imem[i] = i_type(imm, 5'd0, 3'b010, rd, rv_isa_pkg::OP_LOAD);
    end else if (kind < 14) begin
      imem[i] = s_type({4'b0, 6'(pick(DMEM_WORDS)), 2'b00}, rs2, 5'd0);
    end else if (kind < 15) begin
      bf      = pick(6);
      f3      = (bf < 2) ? 3'(bf) : 3'(bf + 2);
      imem[i] = b_type(13'(span * 4), rs2, rs1, f3);
    end else begin
      imem[i] = j_type(21'(span * 4), rd);
    end
  end
  imem[HALT_IDX] = j_type(21'd0, 5'd0);
endtask

// ---------------------------------------------------------------------------
// Instruction-level reference model
// ---------------------------------------------------------------------------
function automatic cpu_cfg_pkg::word_t alu_ref(logic [2:0] f3, logic alt,
                                               cpu_cfg_pkg::word_t a,
                                               cpu_cfg_pkg::word_t b);
  case (f3)
    3'b000: return alt ? a - b : a + b;
    3'b001: return a << b[4:0];
    3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    3'b011: return (a < b) ? 32'd1 : 32'd0;
    3'b100: return a ^ b;
    3'b101: begin
      if (alt) begin
        return $signed(a) >>> b[4:0];
      end
      return a >> b[4:0];
    end
    3'b110: return a | b;
    default: return a & b;
  endcase
endfunction

function automatic logic br_taken(logic [2:0] f3, cpu_cfg_pkg::word_t a,
                                  cpu_cfg_pkg::word_t b);
  case (f3)
    3'b000: return a == b;
    3'b001: return a != b;
    3'b100: return $signed(a) < $signed(b);
    3'b101: return $signed(a) >= $signed(b);
    3'b110: return a < b;
    3'b111: return a >= b;
    default: return 1'b0;
  endcase
endfunction

task automatic run_model();
  cpu_cfg_pkg::word_t x [32];
  cpu_cfg_pkg::word_t mem [DMEM_WORDS];
  cpu_cfg_pkg::word_t ins;
  cpu_cfg_pkg::word_t a;
  cpu_cfg_pkg::word_t b;
  cpu_cfg_pkg::word_t imm;
  cpu_cfg_pkg::word_t ea;
  cpu_cfg_pkg::word_t off;
  cpu_cfg_pkg::word_t res;
  logic               wr;
  int                 pc;
  int                 next;
  for (int r = 0; r < 32; r++) begin
    x[r] = '0;
  end
  for (int w = 0; w < DMEM_WORDS; w++) begin
    mem[w] = dmem_fill(w);
  end
  model_loads = 0;
  pc          = 0;
  // All jumps go forward, so the halt is always reached
  while (pc != HALT_IDX) begin
    ins  = imem[pc];
    a    = x[ins[19:15]];
    b    = x[ins[24:20]];
    imm  = {{20{ins[31]}}, ins[31:20]};
    res  = '0;
    wr   = 1'b0;
    next = pc + 1;
    case (rv_isa_pkg::opcode_e'(ins[6:0]))
      rv_isa_pkg::OP_REG: begin
        res = alu_ref(ins[14:12], ins[30], a, b);
        wr  = 1'b1;
      end
      rv_isa_pkg::OP_IMM: begin
        res = alu_ref(ins[14:12], ins[30] && ins[14:12] == 3'b101, a, imm);
        wr  = 1'b1;
      end
      rv_isa_pkg::OP_LUI: begin
        res = {ins[31:12], 12'b0};
        wr  = 1'b1;
      end
      rv_isa_pkg::OP_LOAD: begin
        ea  = a + imm;
        res = mem[ea[7:2]];
        wr  = 1'b1;
        model_loads++;
      end
      rv_isa_pkg::OP_STORE: begin
        ea          = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
        mem[ea[7:2]] = b;
        st_addr_q.push_back(ea[cpu_cfg_pkg::DM_AW+1:2]);
        st_data_q.push_back(b);
      end
      rv_isa_pkg::OP_BRANCH: begin
        off = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        if (br_taken(ins[14:12], a, b)) begin
          next = pc + int'($signed(off) >>> 2);
        end
      end
      rv_isa_pkg::OP_JAL: begin
        off  = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        res  = 32'((pc + 1) * 4);
        wr   = 1'b1;
        next = pc + int'($signed(off) >>> 2);
      end
      default: ;
    endcase
    if (wr && ins[11:7] != 5'd0) begin
      x[ins[11:7]] = res;
    end
    pc = next;
  end
endtask

`endif

/* tb/cpu_tb.sv */
`timescale 1ns/1ps

module cpu_tb;

  localparam int CLK_PERIOD = 40;
  localparam int RST_CYCLES = 8;
  localparam int STIM_DELAY = 2;

  typedef logic [cpu_cfg_pkg::IM_AW-1:0] im_addr_t;
  typedef logic [cpu_cfg_pkg::DM_AW-1:0] dm_addr_t;

  logic               clk_i;
  logic               rst_n_i;
  im_addr_t           im_addr_o;
  cpu_cfg_pkg::word_t im_data_i;
  logic               dm_re_o;
  logic               dm_we_o;
  dm_addr_t           dm_addr_o;
  cpu_cfg_pkg::word_t dm_wdata_o;
  cpu_cfg_pkg::word_t dm_data_i;

  int                 reset_err;
  int                 store_err;
  int                 count_err;
  int                 st_cnt;
  int                 ld_cnt;

  `include "rv_ref_model.svh"

  cpu_cfg_pkg::word_t dmem [DMEM_WORDS];

  cpu_top i_cpu_top (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .im_addr_o (im_addr_o),
    .im_data_i (im_data_i),
    .dm_re_o   (dm_re_o),
    .dm_we_o   (dm_we_o),
    .dm_addr_o (dm_addr_o),
    .dm_wdata_o(dm_wdata_o),
    .dm_data_i (dm_data_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // Memories answer the addresses registered at the last edge
  always @(posedge clk_i) begin
    #(STIM_DELAY);
    im_data_i = imem[im_addr_o[7:0]];
    dm_data_i = dmem[dm_addr_o[5:0]];
  end

  task automatic check_store();
    assert (st_cnt < st_addr_q.size()) else begin
      $display("Extra store number %0d at time %0t, the model has no more stores",
               st_cnt + 1, $time);
      store_err++;
    end
    if (st_cnt < st_addr_q.size()) begin
      assert (dm_addr_o == st_addr_q[st_cnt] && dm_wdata_o == st_data_q[st_cnt]) else begin
        $display("mismatch at %0t: store %0d wrote [%0h] = %08h, expected [%0h] = %08h",
                 $time, st_cnt, dm_addr_o, dm_wdata_o, st_addr_q[st_cnt],
                 st_data_q[st_cnt]);
        store_err++;
      end
    end
    dmem[dm_addr_o[5:0]] = dm_wdata_o;
    st_cnt++;
  endtask

  // Strobes sampled mid-cycle
  always @(negedge clk_i) begin
    if (rst_n_i === 1'b1) begin
      if (dm_we_o) begin
        check_store();
      end
      if (dm_re_o) begin
        ld_cnt++;
      end
    end
  end

  // ---------------------------------------------------------------------------
  // Main sequence
  // ---------------------------------------------------------------------------
  initial begin
    rst_n_i   = 1'b0;
    im_data_i = '0;
    dm_data_i = '0;
    reset_err = 0;
    store_err = 0;
    count_err = 0;
    st_cnt    = 0;
    ld_cnt    = 0;
    gen_program();
    run_model();
    for (int w = 0; w < DMEM_WORDS; w++) begin
      dmem[w] = dmem_fill(w);
    end
    repeat (RST_CYCLES) @(posedge clk_i);
    #(STIM_DELAY);
    rst_n_i = 1'b1;

    // First instruction is fetched now and reaches ME three cycles later
    for (int c = 0; c < 3; c++) begin
      @(negedge clk_i);
      if (c == 0) begin
        assert (im_addr_o == im_addr_t'(cpu_cfg_pkg::RESET_PC >> 2)) else begin
          $display("mismatch at %0t: fetch address %0h after reset", $time, im_addr_o);
          reset_err++;
        end
      end
      assert (!dm_re_o && !dm_we_o) else begin
        $display("mismatch at %0t: memory strobe high before the first ME cycle", $time);
        reset_err++;
      end
    end

    // Halt JAL sits in ID once the word behind it is fetched
    while (im_addr_o != im_addr_t'(HALT_IDX + 1)) begin
      @(negedge clk_i);
    end
    // Older instructions leave ME within the next two cycles
    repeat (2) @(negedge clk_i);

    assert (st_cnt == st_addr_q.size()) else begin
      $display("mismatch at %0t: %0d stores seen, model made %0d",
               $time, st_cnt, st_addr_q.size());
      count_err++;
    end
    assert (ld_cnt == model_loads) else begin
      $display("mismatch at %0t: %0d loads seen, model made %0d",
               $time, ld_cnt, model_loads);
      count_err++;
    end

    $display("Errors: reset %0d, store %0d, count %0d (stores %0d, loads %0d)",
             reset_err, store_err, count_err, st_cnt, ld_cnt);
    if (reset_err + store_err + count_err == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // Watchdog budget of four cycles per instruction plus margin
  initial begin
    repeat (RST_CYCLES + PROG_LEN * 4 + 50) @(posedge clk_i);
    $display("Timeout: the core did not reach the halt loop within %0d cycles",
             RST_CYCLES + PROG_LEN * 4 + 50);
    $display("TEST FAIL");
    $finish;
  end

endmodule

/* tb/cpu_checker.sv */
`timescale 1ns/1ps

module cpu_checker (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          dm_re_i,
  input  logic                          dm_we_i,
  input  logic [cpu_cfg_pkg::IM_AW-1:0] im_addr_i,
  input  logic                          stall_i,
  input  logic                          valid_id_i,
  input  logic                          ex_wen_i,
  input  logic                          ex_mem_write_i
);

  // One data memory access per cycle at most
  a_rw_exclusive: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(dm_re_i && dm_we_i))
    else $error("Data memory read and write strobes are high in the same cycle");

  // PC frozen while the hazard unit stalls
  a_stall_holds_pc: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    stall_i |=> $stable(im_addr_i))
    else $error("Fetch address moved during a stall");

  // Slot killed by a taken branch or JAL enters EX as a bubble
  a_flush_bubble: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !valid_id_i |=> (!ex_wen_i && !ex_mem_write_i))
    else $error("Flushed decode slot reached EX with a write enable");

endmodule

bind cpu_top cpu_checker i_cpu_checker (
  .clk_i         (clk_i),
  .rst_n_i       (rst_n_i),
  .dm_re_i       (dm_re_o),
  .dm_we_i       (dm_we_o),
  .im_addr_i     (im_addr_o),
  .stall_i       (i_hazard_if.stall),
  .valid_id_i    (i_fetch_decode.valid_id_q),
  .ex_wen_i      (id_ex.wen),
  .ex_mem_write_i(id_ex.mem_write)
);

/* rtl/cpu_top.sv */
`timescale 1ns/1ps

module cpu_top (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  output logic [cpu_cfg_pkg::IM_AW-1:0] im_addr_o,
  input  cpu_cfg_pkg::word_t            im_data_i,
  output logic                          dm_re_o,
  output logic                          dm_we_o,
  output logic [cpu_cfg_pkg::DM_AW-1:0] dm_addr_o,
  output cpu_cfg_pkg::word_t            dm_wdata_o,
  input  cpu_cfg_pkg::word_t            dm_data_i
);

  cpu_cfg_pkg::id_ex_t  id_ex;
  cpu_cfg_pkg::word_t   me_fwd_data;
  rv_isa_pkg::reg_idx_t wb_rd;
  cpu_cfg_pkg::word_t   wb_data;
  logic                 wb_wen;

  hazard_if i_hazard_if ();

  fetch_decode i_fetch_decode (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .im_addr_o    (im_addr_o),
    .im_data_i    (im_data_i),
    .hz           (i_hazard_if.id),
    .me_fwd_data_i(me_fwd_data),
    .wb_rd_i      (wb_rd),
    .wb_data_i    (wb_data),
    .wb_wen_i     (wb_wen),
    .id_ex_o      (id_ex)
  );

  execute_mem i_execute_mem (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .id_ex_i      (id_ex),
    .hz           (i_hazard_if.ex),
    .dm_re_o      (dm_re_o),
    .dm_we_o      (dm_we_o),
    .dm_addr_o    (dm_addr_o),
    .dm_wdata_o   (dm_wdata_o),
    .dm_data_i    (dm_data_i),
    .me_fwd_data_o(me_fwd_data),
    .wb_rd_o      (wb_rd),
    .wb_data_o    (wb_data),
    .wb_wen_o     (wb_wen)
  );

  hazard_unit i_hazard_unit (
    .hz(i_hazard_if.hz)
  );

endmodule

/* rtl/hazard_unit.sv */
`timescale 1ns/1ps

module hazard_unit (
  hazard_if.hz hz
);

  logic ex_dep;
  logic me_dep;

  // Match on a written, nonzero destination
  function automatic logic hit(rv_isa_pkg::reg_idx_t src, rv_isa_pkg::reg_idx_t dst,
                               logic wen);
    return wen && (dst != '0) && (dst == src);
  endfunction

  // ALU operand forwarding, the younger ME result wins
  always_comb begin
    hz.fwd_a = cpu_cfg_pkg::FWD_NONE;
    hz.fwd_b = cpu_cfg_pkg::FWD_NONE;
    if (hit(hz.rs1_ex, hz.rd_me, hz.wen_me)) begin
      hz.fwd_a = cpu_cfg_pkg::FWD_ME;
    end else if (hit(hz.rs1_ex, hz.rd_wb, hz.wen_wb)) begin
      hz.fwd_a = cpu_cfg_pkg::FWD_WB;
    end
    if (hit(hz.rs2_ex, hz.rd_me, hz.wen_me)) begin
      hz.fwd_b = cpu_cfg_pkg::FWD_ME;
    end else if (hit(hz.rs2_ex, hz.rd_wb, hz.wen_wb)) begin
      hz.fwd_b = cpu_cfg_pkg::FWD_WB;
    end
  end

  // Load data in ME is too late for the comparator
  assign hz.cmp_fwd_a = hit(hz.rs1_id, hz.rd_me, hz.wen_me && !hz.load_me);
  assign hz.cmp_fwd_b = hit(hz.rs2_id, hz.rd_me, hz.wen_me && !hz.load_me);

  assign ex_dep = (hz.uses_rs1_id && hit(hz.rs1_id, hz.rd_ex, hz.wen_ex)) ||
                  (hz.uses_rs2_id && hit(hz.rs2_id, hz.rd_ex, hz.wen_ex));
  assign me_dep = (hz.uses_rs1_id && hit(hz.rs1_id, hz.rd_me, hz.wen_me)) ||
                  (hz.uses_rs2_id && hit(hz.rs2_id, hz.rd_me, hz.wen_me));

  // Load-use, branch on EX result, branch on load in ME
  assign hz.stall = (ex_dep && (hz.load_ex || hz.is_branch_id)) ||
                    (me_dep && hz.load_me && hz.is_branch_id);

endmodule

/* rtl/execute_mem.sv */
`timescale 1ns/1ps

module execute_mem (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  cpu_cfg_pkg::id_ex_t           id_ex_i,
  hazard_if.ex                          hz,
  output logic                          dm_re_o,
  output logic                          dm_we_o,
  output logic [cpu_cfg_pkg::DM_AW-1:0] dm_addr_o,
  output cpu_cfg_pkg::word_t            dm_wdata_o,
  input  cpu_cfg_pkg::word_t            dm_data_i,
  output cpu_cfg_pkg::word_t            me_fwd_data_o,
  output logic [4:0]                    wb_rd_o,
  output cpu_cfg_pkg::word_t            wb_data_o,
  output logic                          wb_wen_o
);

  cpu_cfg_pkg::word_t    op_a;
  cpu_cfg_pkg::word_t    rs2_fwd;
  cpu_cfg_pkg::word_t    op_b;
  cpu_cfg_pkg::word_t    alu_y;
  cpu_cfg_pkg::word_t    me_alu_q;
  cpu_cfg_pkg::word_t    me_link_q;
  cpu_cfg_pkg::word_t    me_store_q;
  logic [4:0]            me_rd_q;
  logic                  me_wen_q;
  logic                  me_read_q;
  logic                  me_write_q;
  cpu_cfg_pkg::wb_sel_e  me_wb_sel_q;

  function automatic cpu_cfg_pkg::word_t fwd_mux(cpu_cfg_pkg::fwd_sel_e sel,
                                                 cpu_cfg_pkg::word_t id_val,
                                                 cpu_cfg_pkg::word_t me_val,
                                                 cpu_cfg_pkg::word_t wb_val);
    case (sel)
      cpu_cfg_pkg::FWD_ME: return me_val;
      cpu_cfg_pkg::FWD_WB: return wb_val;
      default:             return id_val;
    endcase
  endfunction

  // -------------------------------------------------------------------------
  // Execute
  // -------------------------------------------------------------------------
  assign op_a    = fwd_mux(hz.fwd_a, id_ex_i.rs1_data, me_fwd_data_o, wb_data_o);
  assign rs2_fwd = fwd_mux(hz.fwd_b, id_ex_i.rs2_data, me_fwd_data_o, wb_data_o);
  assign op_b    = id_ex_i.use_imm ? id_ex_i.imm : rs2_fwd;

  alu i_alu (
    .a_i (op_a),
    .b_i (op_b),
    .op_i(id_ex_i.alu_op),
    .y_o (alu_y)
  );

  // EX/ME register, store data already forwarded
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      me_wen_q   <= 1'b0;
      me_read_q  <= 1'b0;
      me_write_q <= 1'b0;
    end else begin
      me_wen_q   <= id_ex_i.wen;
      me_read_q  <= id_ex_i.mem_read;
      me_write_q <= id_ex_i.mem_write;
    end
    me_alu_q    <= alu_y;
    me_link_q   <= id_ex_i.link;
    me_store_q  <= rs2_fwd;
    me_rd_q     <= id_ex_i.rd;
    me_wb_sel_q <= id_ex_i.wb_sel;
  end

  // -------------------------------------------------------------------------
  // Memory and writeback
  // -------------------------------------------------------------------------
  assign dm_re_o    = me_read_q;
  assign dm_we_o    = me_write_q;
  assign dm_addr_o  = me_alu_q[cpu_cfg_pkg::DM_AW+1:2];
  assign dm_wdata_o = me_store_q;

  always_comb begin
    case (me_wb_sel_q)
      cpu_cfg_pkg::WB_LINK: me_fwd_data_o = me_link_q;
      cpu_cfg_pkg::WB_LOAD: me_fwd_data_o = dm_data_i;
      default:              me_fwd_data_o = me_alu_q;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wb_wen_o <= 1'b0;
    end else begin
      wb_wen_o <= me_wen_q;
    end
    wb_rd_o   <= me_rd_q;
    wb_data_o <= me_fwd_data_o;
  end

  // State seen by the hazard unit
  assign hz.rs1_ex  = id_ex_i.rs1;
  assign hz.rs2_ex  = id_ex_i.rs2;
  assign hz.rd_ex   = id_ex_i.rd;
  assign hz.wen_ex  = id_ex_i.wen;
  assign hz.load_ex = id_ex_i.mem_read;
  assign hz.rd_me   = me_rd_q;
  assign hz.wen_me  = me_wen_q;
  assign hz.load_me = me_read_q;
  assign hz.rd_wb   = wb_rd_o;
  assign hz.wen_wb  = wb_wen_o;

endmodule

/* rtl/fetch_decode.sv */
`timescale 1ns/1ps

module fetch_decode (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  output logic [cpu_cfg_pkg::IM_AW-1:0]  im_addr_o,
  input  cpu_cfg_pkg::word_t             im_data_i,
  hazard_if.id                           hz,
  input  cpu_cfg_pkg::word_t             me_fwd_data_i,
  input  rv_isa_pkg::reg_idx_t           wb_rd_i,
  input  cpu_cfg_pkg::word_t             wb_data_i,
  input  logic                           wb_wen_i,
  output cpu_cfg_pkg::id_ex_t            id_ex_o
);

  cpu_cfg_pkg::word_t   pc_q;
  cpu_cfg_pkg::word_t   pc_id_q;
  cpu_cfg_pkg::word_t   ir;
  logic                 valid_id_q;
  rv_isa_pkg::opcode_e  opcode;
  logic [2:0]           f3;
  rv_isa_pkg::reg_idx_t rs1;
  rv_isa_pkg::reg_idx_t rs2;
  cpu_cfg_pkg::word_t   imm_i;
  cpu_cfg_pkg::word_t   imm_s;
  cpu_cfg_pkg::word_t   imm_b;
  cpu_cfg_pkg::word_t   imm_u;
  cpu_cfg_pkg::word_t   imm_j;
  cpu_cfg_pkg::word_t   rs1_data;
  cpu_cfg_pkg::word_t   rs2_data;
  cpu_cfg_pkg::word_t   cmp_a;
  cpu_cfg_pkg::word_t   cmp_b;
  logic                 is_branch;
  logic                 is_jal;
  logic                 take;
  cpu_cfg_pkg::id_ex_t  id_ex_d;

  function automatic cpu_cfg_pkg::alu_op_e alu_dec(logic [2:0] fn, logic alt, logic is_reg);
    case (rv_isa_pkg::alu_f3_e'(fn))
      rv_isa_pkg::F3_ADD:  return (is_reg && alt) ? cpu_cfg_pkg::ALU_SUB : cpu_cfg_pkg::ALU_ADD;
      rv_isa_pkg::F3_SLL:  return cpu_cfg_pkg::ALU_SLL;
      rv_isa_pkg::F3_SLT:  return cpu_cfg_pkg::ALU_SLT;
      rv_isa_pkg::F3_SLTU: return cpu_cfg_pkg::ALU_SLTU;
      rv_isa_pkg::F3_XOR:  return cpu_cfg_pkg::ALU_XOR;
      rv_isa_pkg::F3_SR:   return alt ? cpu_cfg_pkg::ALU_SRA : cpu_cfg_pkg::ALU_SRL;
      rv_isa_pkg::F3_OR:   return cpu_cfg_pkg::ALU_OR;
      rv_isa_pkg::F3_AND:  return cpu_cfg_pkg::ALU_AND;
      default:             return cpu_cfg_pkg::ALU_ADD;
    endcase
  endfunction

  function automatic logic br_eval(logic [2:0] fn, cpu_cfg_pkg::word_t a,
                                   cpu_cfg_pkg::word_t b);
    case (rv_isa_pkg::branch_f3_e'(fn))
      rv_isa_pkg::BR_EQ:  return a == b;
      rv_isa_pkg::BR_NE:  return a != b;
      rv_isa_pkg::BR_LT:  return $signed(a) < $signed(b);
      rv_isa_pkg::BR_GE:  return $signed(a) >= $signed(b);
      rv_isa_pkg::BR_LTU: return a < b;
      rv_isa_pkg::BR_GEU: return a >= b;
      default:            return 1'b0;
    endcase
  endfunction

  // -------------------------------------------------------------------------
  // Fetch: PC and IF/ID register
  // -------------------------------------------------------------------------
  assign im_addr_o = pc_q[cpu_cfg_pkg::IM_AW+1:2];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pc_q       <= cpu_cfg_pkg::RESET_PC;
      valid_id_q <= 1'b0;
    end else if (!hz.stall) begin
      pc_q       <= take ? pc_id_q + id_ex_d.imm : pc_q + 32'd4;
      // Taken branch or JAL kills the slot behind it
      valid_id_q <= !take;
      ir         <= im_data_i;
      pc_id_q    <= pc_q;
    end
  end

  // -------------------------------------------------------------------------
  // Decode
  // -------------------------------------------------------------------------
  assign opcode = rv_isa_pkg::opcode_e'(ir[rv_isa_pkg::OPCODE_MSB:rv_isa_pkg::OPCODE_LSB]);
  assign f3     = ir[rv_isa_pkg::F3_LSB +: 3];
  assign rs1    = ir[rv_isa_pkg::RS1_LSB +: 5];
  assign rs2    = ir[rv_isa_pkg::RS2_LSB +: 5];

  assign imm_i = {{20{ir[31]}}, ir[31:20]};
  assign imm_s = {{20{ir[31]}}, ir[31:25], ir[11:7]};
  assign imm_b = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
  assign imm_u = {ir[31:12], 12'b0};
  assign imm_j = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};

  reg_file i_reg_file (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .rs1_i     (rs1),
    .rs2_i     (rs2),
    .rd_i      (wb_rd_i),
    .rd_data_i (wb_data_i),
    .wen_i     (wb_wen_i),
    .rs1_data_o(rs1_data),
    .rs2_data_o(rs2_data)
  );

  always_comb begin
    id_ex_d           = '0;
    id_ex_d.rs1_data  = rs1_data;
    id_ex_d.rs2_data  = rs2_data;
    id_ex_d.imm       = imm_i;
    id_ex_d.link      = pc_id_q + 32'd4;
    id_ex_d.rs1       = rs1;
    id_ex_d.rs2       = rs2;
    id_ex_d.rd        = ir[rv_isa_pkg::RD_LSB +: 5];
    id_ex_d.alu_op    = cpu_cfg_pkg::ALU_ADD;
    id_ex_d.wb_sel    = cpu_cfg_pkg::WB_ALU;
    hz.uses_rs1_id    = 1'b0;
    hz.uses_rs2_id    = 1'b0;
    is_branch         = 1'b0;
    is_jal            = 1'b0;
    if (valid_id_q) begin
      case (opcode)
        rv_isa_pkg::OP_REG: begin
          id_ex_d.wen    = 1'b1;
          id_ex_d.alu_op = alu_dec(f3, ir[rv_isa_pkg::F7_ALT_BIT], 1'b1);
          hz.uses_rs1_id = 1'b1;
          hz.uses_rs2_id = 1'b1;
        end
        rv_isa_pkg::OP_IMM: begin
          id_ex_d.wen     = 1'b1;
          id_ex_d.use_imm = 1'b1;
          id_ex_d.alu_op  = alu_dec(f3, ir[rv_isa_pkg::F7_ALT_BIT], 1'b0);
          hz.uses_rs1_id  = 1'b1;
        end
        rv_isa_pkg::OP_LUI: begin
          id_ex_d.wen     = 1'b1;
          id_ex_d.use_imm = 1'b1;
          id_ex_d.imm     = imm_u;
          id_ex_d.alu_op  = cpu_cfg_pkg::ALU_PASSB;
        end
        rv_isa_pkg::OP_LOAD: begin
          id_ex_d.wen      = 1'b1;
          id_ex_d.use_imm  = 1'b1;
          id_ex_d.mem_read = 1'b1;
          id_ex_d.wb_sel   = cpu_cfg_pkg::WB_LOAD;
          hz.uses_rs1_id   = 1'b1;
        end
        rv_isa_pkg::OP_STORE: begin
          id_ex_d.use_imm   = 1'b1;
          id_ex_d.mem_write = 1'b1;
          id_ex_d.imm       = imm_s;
          hz.uses_rs1_id    = 1'b1;
          hz.uses_rs2_id    = 1'b1;
        end
        rv_isa_pkg::OP_BRANCH: begin
          id_ex_d.imm    = imm_b;
          is_branch      = 1'b1;
          hz.uses_rs1_id = 1'b1;
          hz.uses_rs2_id = 1'b1;
        end
        rv_isa_pkg::OP_JAL: begin
          id_ex_d.wen    = 1'b1;
          id_ex_d.imm    = imm_j;
          id_ex_d.wb_sel = cpu_cfg_pkg::WB_LINK;
          is_jal         = 1'b1;
        end
        default: ;
      endcase
    end
  end

  assign hz.rs1_id       = rs1;
  assign hz.rs2_id       = rs2;
  assign hz.is_branch_id = is_branch;

  // Comparator operands, WB values arrive through the register file
  assign cmp_a = hz.cmp_fwd_a ? me_fwd_data_i : rs1_data;
  assign cmp_b = hz.cmp_fwd_b ? me_fwd_data_i : rs2_data;

  assign take = !hz.stall && (is_jal || (is_branch && br_eval(f3, cmp_a, cmp_b)));

  // -------------------------------------------------------------------------
  // ID/EX register, bubble on stall
  // -------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i || hz.stall) begin
      id_ex_o.wen       <= 1'b0;
      id_ex_o.mem_read  <= 1'b0;
      id_ex_o.mem_write <= 1'b0;
    end else begin
      id_ex_o <= id_ex_d;
    end
  end

endmodule

/* rtl/alu.sv */
`timescale 1ns/1ps

module alu (
  input  cpu_cfg_pkg::word_t   a_i,
  input  cpu_cfg_pkg::word_t   b_i,
  input  cpu_cfg_pkg::alu_op_e op_i,
  output cpu_cfg_pkg::word_t   y_o
);

  logic [4:0] shamt;

  assign shamt = b_i[4:0];

  always_comb begin
    case (op_i)
      cpu_cfg_pkg::ALU_ADD:   y_o = a_i + b_i;
      cpu_cfg_pkg::ALU_SUB:   y_o = a_i - b_i;
      cpu_cfg_pkg::ALU_AND:   y_o = a_i & b_i;
      cpu_cfg_pkg::ALU_OR:    y_o = a_i | b_i;
      cpu_cfg_pkg::ALU_XOR:   y_o = a_i ^ b_i;
      cpu_cfg_pkg::ALU_SLT:   y_o = {31'b0, $signed(a_i) < $signed(b_i)};
      cpu_cfg_pkg::ALU_SLTU:  y_o = {31'b0, a_i < b_i};
      cpu_cfg_pkg::ALU_SLL:   y_o = a_i << shamt;
      cpu_cfg_pkg::ALU_SRL:   y_o = a_i >> shamt;
      cpu_cfg_pkg::ALU_SRA:   y_o = $signed(a_i) >>> shamt;
      // LUI result comes straight from the immediate
      cpu_cfg_pkg::ALU_PASSB: y_o = b_i;
      default:                y_o = '0;
    endcase
  end

endmodule

/* rtl/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  rv_isa_pkg::reg_idx_t rs1_i,
  input  rv_isa_pkg::reg_idx_t rs2_i,
  input  rv_isa_pkg::reg_idx_t rd_i,
  input  cpu_cfg_pkg::word_t   rd_data_i,
  input  logic                 wen_i,
  output cpu_cfg_pkg::word_t   rs1_data_o,
  output cpu_cfg_pkg::word_t   rs2_data_o
);

  cpu_cfg_pkg::word_t regs [rv_isa_pkg::NUM_REGS];
  logic               wr_ok;

  // x0 is never written
  assign wr_ok = wen_i && (rd_i != '0);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < rv_isa_pkg::NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_ok) begin
      regs[rd_i] <= rd_data_i;
    end
  end

  // Write-through so ID sees the value retiring in WB
  assign rs1_data_o = (wr_ok && rd_i == rs1_i) ? rd_data_i : regs[rs1_i];
  assign rs2_data_o = (wr_ok && rd_i == rs2_i) ? rd_data_i : regs[rs2_i];

endmodule

/* rtl/hazard_if.sv */
`timescale 1ns/1ps

interface hazard_if;

  // Decode stage sources
  rv_isa_pkg::reg_idx_t  rs1_id;
  rv_isa_pkg::reg_idx_t  rs2_id;
  logic                  uses_rs1_id;
  logic                  uses_rs2_id;
  logic                  is_branch_id;

  // Execute, memory and writeback state
  rv_isa_pkg::reg_idx_t  rs1_ex;
  rv_isa_pkg::reg_idx_t  rs2_ex;
  rv_isa_pkg::reg_idx_t  rd_ex;
  logic                  wen_ex;
  logic                  load_ex;
  rv_isa_pkg::reg_idx_t  rd_me;
  logic                  wen_me;
  logic                  load_me;
  rv_isa_pkg::reg_idx_t  rd_wb;
  logic                  wen_wb;

  // Hazard unit decisions
  cpu_cfg_pkg::fwd_sel_e fwd_a;
  cpu_cfg_pkg::fwd_sel_e fwd_b;
  logic                  cmp_fwd_a;
  logic                  cmp_fwd_b;
  logic                  stall;

  modport id (
    output rs1_id, rs2_id, uses_rs1_id, uses_rs2_id, is_branch_id,
    input  stall, cmp_fwd_a, cmp_fwd_b
  );

  modport ex (
    output rs1_ex, rs2_ex, rd_ex, wen_ex, load_ex,
    output rd_me, wen_me, load_me, rd_wb, wen_wb,
    input  fwd_a, fwd_b
  );

  modport hz (
    input  rs1_id, rs2_id, uses_rs1_id, uses_rs2_id, is_branch_id,
    input  rs1_ex, rs2_ex, rd_ex, wen_ex, load_ex,
    input  rd_me, wen_me, load_me, rd_wb, wen_wb,
    output fwd_a, fwd_b, cmp_fwd_a, cmp_fwd_b, stall
  );

endinterface

/* rtl/cpu_cfg_pkg.sv */
package cpu_cfg_pkg;

  localparam int XLEN  = 32;
  localparam int IM_AW = 14;
  localparam int DM_AW = 14;

  typedef logic [XLEN-1:0] word_t;

  localparam word_t RESET_PC = '0;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_PASSB
  } alu_op_e;

  typedef enum logic [1:0] {
    WB_ALU,
    WB_LINK,
    WB_LOAD
  } wb_sel_e;

  typedef enum logic [1:0] {
    FWD_NONE,
    FWD_ME,
    FWD_WB
  } fwd_sel_e;

  // ID/EX pipeline contents
  typedef struct packed {
    word_t      rs1_data;
    word_t      rs2_data;
    word_t      imm;
    word_t      link;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [4:0] rd;
    alu_op_e    alu_op;
    logic       use_imm;
    logic       wen;
    logic       mem_read;
    logic       mem_write;
    wb_sel_e    wb_sel;
  } id_ex_t;

endpackage

/* rtl/rv_isa_pkg.sv */
package rv_isa_pkg;

  // Instruction field positions
  localparam int OPCODE_LSB = 0;
  localparam int OPCODE_MSB = 6;
  localparam int RD_LSB     = 7;
  localparam int F3_LSB     = 12;
  localparam int RS1_LSB    = 15;
  localparam int RS2_LSB    = 20;
  localparam int F7_ALT_BIT = 30;

  localparam int NUM_REGS = 32;

  typedef logic [4:0] reg_idx_t;

  typedef enum logic [6:0] {
    OP_REG    = 7'b0110011,
    OP_IMM    = 7'b0010011,
    OP_LUI    = 7'b0110111,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_BRANCH = 7'b1100011,
    OP_JAL    = 7'b1101111
  } opcode_e;

  typedef enum logic [2:0] {
    BR_EQ  = 3'b000,
    BR_NE  = 3'b001,
    BR_LT  = 3'b100,
    BR_GE  = 3'b101,
    BR_LTU = 3'b110,
    BR_GEU = 3'b111
  } branch_f3_e;

  // SRL and SRA share F3_SR, bit 30 tells them apart
  typedef enum logic [2:0] {
    F3_ADD  = 3'b000,
    F3_SLL  = 3'b001,
    F3_SLT  = 3'b010,
    F3_SLTU = 3'b011,
    F3_XOR  = 3'b100,
    F3_SR   = 3'b101,
    F3_OR   = 3'b110,
    F3_AND  = 3'b111
  } alu_f3_e;

endpackage
